// File: list.f
hdl/sme_cfg_pkg.sv
hdl/sme_op_pkg.sv
hdl/sme_regfile.sv
hdl/sme_issue.sv
hdl/sme_alu.sv
hdl/sme_writeback.sv
hdl/sme_state.sv
verification/sme_state_assertions.sv
verification/sme_state_tb.sv

// File: Makefile
SIM       := verilator
TOP       := sme_state_tb
FILELIST  := list.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0
RUN_FLAGS := +verilator+error+limit+100
LOG       := sim.log
PASS_MSG  := NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/sme_state_tb.sv
`timescale 1ns/1ps
`default_nettype none

module sme_state_tb
  import sme_cfg_pkg::*;
  import sme_op_pkg::*;
();

  typedef enum logic [1:0] {
    ROW_STORE,                                     // Bank write
    ROW_INSTR,                                     // Instruction strobe
    ROW_READ                                       // XOR of shares over the bank port
  } row_kind_e;

  typedef struct packed {
    row_kind_e kind;
    sme_op_e   op;
    sme_addr_t rs1;
    sme_addr_t rs2;
    sme_addr_t rd;                                 // Also store / readback register
    sme_bank_t bank;                               // Store bank or first share read
    sme_cnt_t  d;                                  // Share count or readback end
    logic      chk;                                // Compare instr_result_o
    logic      back;                               // Next row strobes right away
    sme_data_t data;                               // Store data or expected value
  } row_t;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  sme_instr_t  instr;
  sme_ctl_t    ctl;
  logic        bank_wen;
  sme_addr_t   bank_waddr;
  sme_data_t   bank_wdata;
  sme_addr_t   bank_raddr;
  sme_data_t   bank_rdata;
  logic        result_valid;
  sme_data_t   instr_result;

  row_t        tbl [$];                            // Stimulus table
  sme_data_t   exp_q [$];                          // Pending results in issue order
  logic        chk_q [$];
  int          due_q [$];                          // Cycle each result is due
  int          cyc;
  int          limit;
  logic [31:0] rnd_state;

  sme_state i_dut (
    .g_clk_i       (clk),
    .rst_n_i       (rst_n),
    .instr_valid_i (instr_valid),
    .instr_i       (instr),
    .ctl_i         (ctl),
    .bank_wen_i    (bank_wen),
    .bank_waddr_i  (bank_waddr),
    .bank_wdata_i  (bank_wdata),
    .bank_raddr_i  (bank_raddr),
    .bank_rdata_o  (bank_rdata),
    .result_valid_o(result_valid),
    .instr_result_o(instr_result)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                         // 100 MHz
  end

  task automatic abort_run();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_data(input sme_data_t exp, input sme_data_t act, input string name);
    if (act !== exp) begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      abort_run();
    end
  endtask

  task automatic check_valid(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      $display("ERR %0t %s expected %b actual %b", $time, name, exp, act);
      abort_run();
    end
  endtask

  // xorshift32 for plain test values
  function automatic sme_data_t next_rand();
    rnd_state = rnd_state ^ (rnd_state << 13);
    rnd_state = rnd_state ^ (rnd_state >> 17);
    rnd_state = rnd_state ^ (rnd_state << 5);
    return rnd_state;
  endfunction

  // Table rows
  // ------------------------------
  function automatic void store_row(input sme_bank_t bank, input sme_addr_t addr,
                                    input sme_data_t data);
    row_t r;
    r      = '0;
    r.kind = ROW_STORE;
    r.bank = bank;
    r.rd   = addr;
    r.data = data;
    tbl.push_back(r);
  endfunction

  function automatic void instr_row(input sme_op_e op, input sme_addr_t rs1,
                                    input sme_addr_t rs2, input sme_addr_t rd,
                                    input sme_cnt_t d, input logic chk,
                                    input sme_data_t exp, input logic back);
    row_t r;
    r      = '0;
    r.kind = ROW_INSTR;
    r.op   = op;
    r.rs1  = rs1;
    r.rs2  = rs2;
    r.rd   = rd;
    r.d    = d;
    r.chk  = chk;
    r.data = exp;
    r.back = back;
    tbl.push_back(r);
  endfunction

  function automatic void readback_row(input sme_addr_t addr, input sme_bank_t first,
                                       input sme_cnt_t last, input sme_data_t exp);
    row_t r;
    r      = '0;
    r.kind = ROW_READ;
    r.rd   = addr;
    r.bank = first;
    r.d    = last;
    r.data = exp;
    tbl.push_back(r);
  endfunction

  task automatic apply_row(input row_t r);
    sme_data_t acc;
    acc = '0;
    @(posedge clk);
    instr_valid <= 1'b0;                           // Strobes last one cycle
    bank_wen    <= 1'b0;
    case (r.kind)
      ROW_STORE: begin
        ctl.b      <= r.bank;
        bank_waddr <= r.rd;
        bank_wdata <= r.data;
        bank_wen   <= 1'b1;
      end
      ROW_INSTR: begin
        ctl.d       <= r.d;
        instr       <= '{op: r.op, rs1_addr: r.rs1, rs2_addr: r.rs2, rd_addr: r.rd};
        instr_valid <= 1'b1;
        exp_q.push_back(r.data);
        chk_q.push_back(r.chk);
        due_q.push_back(cyc + 3);                  // Two edges after the strobe edge
        if (!r.back) begin
          @(posedge clk);
          instr_valid <= 1'b0;
          while (due_q.size() != 0) begin
            @(posedge clk);
          end
        end
      end
      default: begin
        for (int k = int'(r.bank); k < int'(r.d); k++) begin
          ctl.b      <= sme_bank_t'(k);
          bank_raddr <= r.rd;
          @(negedge clk);
          acc = acc ^ bank_rdata;                  // Fold share k
          if (k < int'(r.d) - 1) begin
            @(posedge clk);
          end
        end
        check_data(r.data, acc, "bank_rdata_o");
      end
    endcase
  endtask

  // Result monitor
  // ------------------------------
  always @(negedge clk) begin
    sme_data_t exp_v;
    logic      chk_v;
    if (due_q.size() != 0 && cyc == due_q[0]) begin
      if (!result_valid) begin
        $display("No result_valid_o for the instruction due in cycle %0d", cyc);
        abort_run();
      end
      exp_v = exp_q.pop_front();
      chk_v = chk_q.pop_front();
      void'(due_q.pop_front());
      if (chk_v) begin
        check_data(exp_v, instr_result, "instr_result_o");
      end
    end else begin
      check_valid(1'b0, result_valid, "result_valid_o");   // Stray or extra result
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= limit) begin
      $display("Run did not finish within %0d cycles", limit);
      abort_run();
    end
  end

  initial begin
    sme_data_t a;
    sme_data_t b;
    sme_data_t c;
    sme_data_t v;
    cyc         = 0;
    limit       = 1000;
    rnd_state   = 32'hbbb7_1380;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    ctl         = '{d: sme_cnt_t'(1), b: '0};
    bank_wen    = 1'b0;
    bank_waddr  = '0;
    bank_wdata  = '0;
    bank_raddr  = '0;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    v = next_rand();

    readback_row(4'd5, 2'd0, 3'd4, '0);            // Zero after reset
    readback_row(4'd15, 2'd0, 3'd4, '0);
    store_row(2'd2, 4'd5, v);
    readback_row(4'd5, 2'd2, 3'd3, v);             // Bank 2 alone
    store_row(2'd0, 4'd1, a);
    instr_row(OP_MASK, 4'd1, 4'd0, 4'd2, 3'd4, 1'b0, '0, 1'b0);
    readback_row(4'd2, 2'd0, 3'd4, a);
    instr_row(OP_UNMASK, 4'd2, 4'd0, 4'd5, 3'd4, 1'b1, a, 1'b0);
    readback_row(4'd5, 2'd1, 3'd4, '0);            // Shares 1 to 3 cleared, v in bank 2 too
    store_row(2'd0, 4'd4, b);
    instr_row(OP_MASK, 4'd4, 4'd0, 4'd6, 3'd4, 1'b0, '0, 1'b0);
    instr_row(OP_XOR, 4'd2, 4'd6, 4'd7, 3'd4, 1'b0, '0, 1'b0);
    readback_row(4'd7, 2'd0, 3'd4, a ^ b);
    instr_row(OP_UNMASK, 4'd7, 4'd0, 4'd8, 3'd4, 1'b1, a ^ b, 1'b0);
    store_row(2'd0, 4'd9, c);
    instr_row(OP_NOT, 4'd0, 4'd9, 4'd10, 3'd1, 1'b1, ~c, 1'b0);
    instr_row(OP_REMASK, 4'd6, 4'd0, 4'd11, 3'd4, 1'b0, '0, 1'b0);
    readback_row(4'd11, 2'd0, 3'd4, b);            // Same value with new shares
    // Three independent strobes on consecutive edges
    instr_row(OP_XOR, 4'd1, 4'd4, 4'd12, 3'd1, 1'b1, a ^ b, 1'b1);
    instr_row(OP_XOR, 4'd9, 4'd1, 4'd13, 3'd1, 1'b1, c ^ a, 1'b1);
    instr_row(OP_NOT, 4'd0, 4'd4, 4'd14, 3'd1, 1'b1, ~b, 1'b0);
    limit = tbl.size() * 8 + 50;

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    foreach (tbl[i]) begin
      apply_row(tbl[i]);
    end
    @(posedge clk);
    instr_valid <= 1'b0;
    bank_wen    <= 1'b0;
    repeat (4) @(posedge clk);                     // Room for a stray result
    if (i_dut.i_assertions.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("%0d assertion failures", i_dut.i_assertions.fail_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "assertion failures");
    end
  end

endmodule

`default_nettype wire

// File: verification/sme_state_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module sme_state_assertions (
  input wire g_clk_i,
  input wire rst_n_i,
  input wire instr_valid_i,                        // Strobe at the DUT port
  input wire result_valid_i                        // DUT result_valid_o
);

  int fail_cnt = 0;                                // Assertion failures so far

  // Strobe captured at one edge, result high two edges later
  a_strobe_result: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
    $past(instr_valid_i, 2) |-> result_valid_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("strobe not followed by result_valid_o");
    end

  // No result without a strobe
  a_result_strobe: assert property (@(posedge g_clk_i) disable iff (!rst_n_i)
    result_valid_i |-> $past(instr_valid_i, 2))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("result_valid_o without a strobe");
    end

  a_reset_quiet: assert property (@(posedge g_clk_i)
    $past(!rst_n_i) |-> !result_valid_i)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("result_valid_o high after reset");
    end

endmodule

bind sme_state sme_state_assertions i_assertions (
  .g_clk_i       (g_clk_i),
  .rst_n_i       (rst_n_i),
  .instr_valid_i (instr_valid_i),
  .result_valid_i(result_valid_o)
);

`default_nettype wire

// File: hdl/sme_state.sv
`timescale 1ns/1ps
`default_nettype none

module sme_state
  import sme_cfg_pkg::*;
  import sme_op_pkg::*;
(
  input  wire        g_clk_i,                      // Global clock
  input  wire        rst_n_i,                      // Async reset, active low
  input  wire        instr_valid_i,                // One-cycle instruction strobe
  input  sme_instr_t instr_i,
  input  sme_ctl_t   ctl_i,                        // Share count and bank select
  input  wire        bank_wen_i,                   // Store into bank ctl_i.b
  input  sme_addr_t  bank_waddr_i,
  input  sme_data_t  bank_wdata_i,
  input  sme_addr_t  bank_raddr_i,                 // Load from bank ctl_i.b
  output sme_data_t  bank_rdata_o,
  output wire        result_valid_o,
  output sme_data_t  instr_result_o                // Share 0 of rd
);

  sme_addr_t            rs1_addr;
  sme_addr_t            rs2_addr;
  sme_shares_t          rs1_shares;                // Share i from bank i
  sme_shares_t          rs2_shares;
  sme_shares_t          bank_rd;                   // Load port, every bank
  logic                 opnd_valid;
  sme_opnd_t            opnd;
  logic                 wb_valid;
  sme_wb_t              wb;
  logic      [SMAX-1:0] rf_wen;
  sme_addr_t [SMAX-1:0] rf_addr;
  sme_shares_t          rf_wdata;

  // Pipeline stages
  // ------------------------------
  sme_issue i_issue (
    .g_clk_i      (g_clk_i),
    .rst_n_i      (rst_n_i),
    .instr_valid_i(instr_valid_i),
    .instr_i      (instr_i),
    .ctl_i        (ctl_i),
    .rs1_shares_i (rs1_shares),
    .rs2_shares_i (rs2_shares),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .opnd_valid_o (opnd_valid),
    .opnd_o       (opnd)
  );

  sme_alu i_alu (
    .g_clk_i      (g_clk_i),
    .rst_n_i      (rst_n_i),
    .opnd_valid_i (opnd_valid),
    .opnd_i       (opnd),
    .wb_valid_o   (wb_valid),
    .wb_o         (wb)
  );

  sme_writeback i_writeback (
    .wb_valid_i    (wb_valid),
    .wb_i          (wb),
    .bank_wen_i    (bank_wen_i),
    .bank_sel_i    (ctl_i.b),
    .bank_waddr_i  (bank_waddr_i),
    .bank_wdata_i  (bank_wdata_i),
    .rf_wen_o      (rf_wen),
    .rf_addr_o     (rf_addr),
    .rf_wdata_o    (rf_wdata),
    .result_valid_o(result_valid_o),
    .instr_result_o(instr_result_o)
  );

  // Share banks
  // ------------------------------
  for (genvar i = 0; i < SMAX; i++) begin : gen_bank
    sme_regfile i_rf (
      .g_clk_i    (g_clk_i),
      .rst_n_i    (rst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .rd_addr_i  (rf_addr[i]),
      .wen_i      (rf_wen[i]),
      .wdata_i    (rf_wdata[i]),
      .raddr_i    (bank_raddr_i),
      .rs1_rdata_o(rs1_shares[i]),
      .rs2_rdata_o(rs2_shares[i]),
      .rdata_o    (bank_rd[i])
    );
  end

  assign bank_rdata_o = bank_rd[ctl_i.b];          // Load port bank select

endmodule

`default_nettype wire

// File: hdl/sme_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module sme_writeback
  import sme_cfg_pkg::*;
  import sme_op_pkg::*;
(
  input  wire                  wb_valid_i,         // ALU writeback strobe
  input  sme_wb_t              wb_i,               // rd address and shares
  input  wire                  bank_wen_i,         // Bank store strobe
  input  sme_bank_t            bank_sel_i,         // Bank targeted by the store
  input  sme_addr_t            bank_waddr_i,
  input  sme_data_t            bank_wdata_i,
  output logic      [SMAX-1:0] rf_wen_o,           // Per-bank write enable
  output sme_addr_t [SMAX-1:0] rf_addr_o,          // Per-bank write address
  output sme_shares_t          rf_wdata_o,         // Per-bank write data
  output wire                  result_valid_o,
  output sme_data_t            instr_result_o
);

  logic [SMAX-1:0] bank_hit;                       // Store aimed at this bank

  // Write port merge
  // ------------------------------
  always_comb begin
    for (int i = 0; i < SMAX; i++) begin
      bank_hit[i] = bank_wen_i && (bank_sel_i == sme_bank_t'(i));
      rf_wen_o[i] = bank_hit[i] || wb_valid_i;
      if (bank_hit[i]) begin                       // Store wins over ALU
        rf_addr_o[i]  = bank_waddr_i;
        rf_wdata_o[i] = bank_wdata_i;
      end else begin
        rf_addr_o[i]  = wb_i.rd_addr;
        rf_wdata_o[i] = wb_i.rd[i];                // Share i lands in bank i
      end
    end
  end

  // Result back to the core
  assign result_valid_o = wb_valid_i;
  assign instr_result_o = wb_i.rd[0];              // Share 0 only

endmodule

`default_nettype wire

// File: hdl/sme_alu.sv
`timescale 1ns/1ps
`default_nettype none

module sme_alu
  import sme_cfg_pkg::*;
  import sme_op_pkg::*;
(
  input  wire       g_clk_i,                       // Global clock
  input  wire       rst_n_i,                       // Async reset, active low
  input  wire       opnd_valid_i,                  // Operand strobe from issue
  input  sme_opnd_t opnd_i,
  output wire       wb_valid_o,                    // Writeback strobe
  output sme_wb_t   wb_o
);

  sme_data_t   prng_q;                             // Generator state
  sme_shares_t rnd;                                // Per-share fresh words
  sme_shares_t rd_shares;
  logic        wb_valid_q;
  sme_wb_t     wb_q;

  // One xorshift32 step
  function automatic sme_data_t xs32(input sme_data_t s);
    sme_data_t t;
    t = s ^ (s << 13);
    t = t ^ (t >> 17);
    t = t ^ (t << 5);
    return t;
  endfunction

  // Mask generator
  // ------------------------------
  always_comb begin
    sme_data_t s;
    s = prng_q;
    for (int k = 1; k < SMAX; k++) begin
      s      = xs32(s);
      rnd[k] = s;                                  // Word for share k
    end
    rnd[0] = xs32(s);                              // Slot 0 is the next state
  end

  always_ff @(posedge g_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prng_q <= PRNG_SEED;
    end else if (opnd_valid_i) begin
      prng_q <= rnd[0];                            // Step once per operation
    end
  end

  // Share-wise datapath
  // ------------------------------
  always_comb begin
    sme_data_t acc;
    rd_shares = '0;
    acc       = '0;
    case (opnd_i.op)
      OP_XOR: begin
        rd_shares = opnd_i.rs1 ^ opnd_i.rs2;       // Linear, share by share
      end
      OP_NOT: begin
        rd_shares    = opnd_i.rs2;
        rd_shares[0] = ~opnd_i.rs2[0];             // Inverting one share is enough
      end
      OP_MASK: begin
        acc = opnd_i.rs1[0];                       // Plain value
        for (int k = 1; k < SMAX; k++) begin
          if (sme_cnt_t'(k) < opnd_i.d) begin
            rd_shares[k] = rnd[k];
            acc          = acc ^ rnd[k];
          end
        end
        rd_shares[0] = acc;
      end
      OP_UNMASK: begin
        for (int k = 0; k < SMAX; k++) begin
          if (sme_cnt_t'(k) < opnd_i.d) begin
            acc = acc ^ opnd_i.rs1[k];
          end
        end
        rd_shares[0] = acc;                        // Others stay zero
      end
      OP_REMASK: begin
        rd_shares = opnd_i.rs1;
        for (int k = 1; k < SMAX; k++) begin
          if (sme_cnt_t'(k) < opnd_i.d) begin
            rd_shares[k] = opnd_i.rs1[k] ^ rnd[k];
            acc          = acc ^ rnd[k];           // Same word into share 0
          end
        end
        rd_shares[0] = opnd_i.rs1[0] ^ acc;
      end
      default: begin
        rd_shares = '0;
      end
    endcase
    // Shares beyond d are written as zero
    for (int k = 0; k < SMAX; k++) begin
      if (sme_cnt_t'(k) >= opnd_i.d) begin
        rd_shares[k] = '0;
      end
    end
  end

  always_ff @(posedge g_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= opnd_valid_i;
    end
  end

  always_ff @(posedge g_clk_i) begin
    if (opnd_valid_i) begin
      wb_q.rd_addr <= opnd_i.rd_addr;
      wb_q.rd      <= rd_shares;
    end
  end

  assign wb_valid_o = wb_valid_q;
  assign wb_o       = wb_q;

endmodule

`default_nettype wire

// File: hdl/sme_issue.sv
`timescale 1ns/1ps
`default_nettype none

module sme_issue
  import sme_cfg_pkg::*;
  import sme_op_pkg::*;
(
  input  wire         g_clk_i,                     // Global clock
  input  wire         rst_n_i,                     // Async reset, active low
  input  wire         instr_valid_i,               // One-cycle instruction strobe
  input  sme_instr_t  instr_i,                     // Valid with the strobe only
  input  sme_ctl_t    ctl_i,                       // smectl, stable in flight
  input  sme_shares_t rs1_shares_i,                // rs1 from every bank
  input  sme_shares_t rs2_shares_i,                // rs2 from every bank
  output sme_addr_t   rs1_addr_o,
  output sme_addr_t   rs2_addr_o,
  output wire         opnd_valid_o,
  output sme_opnd_t   opnd_o
);

  logic      opnd_valid_q;
  sme_opnd_t opnd_q;
  sme_cnt_t  d_clamp;

  // Banks are addressed straight from the incoming instruction
  assign rs1_addr_o = instr_i.rs1_addr;
  assign rs2_addr_o = instr_i.rs2_addr;

  // Keep d inside 1..SMAX
  always_comb begin
    d_clamp = ctl_i.d;
    if (ctl_i.d == '0) begin
      d_clamp = sme_cnt_t'(1);                     // Zero shares acts as one
    end else if (ctl_i.d > sme_cnt_t'(SMAX)) begin
      d_clamp = sme_cnt_t'(SMAX);
    end
  end

  always_ff @(posedge g_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      opnd_valid_q <= 1'b0;
    end else begin
      opnd_valid_q <= instr_valid_i;               // Strobe, one stage later
    end
  end

  // Operand capture
  always_ff @(posedge g_clk_i) begin
    if (instr_valid_i) begin
      opnd_q.op      <= instr_i.op;
      opnd_q.rd_addr <= instr_i.rd_addr;
      opnd_q.d       <= d_clamp;
      opnd_q.rs1     <= rs1_shares_i;
      opnd_q.rs2     <= rs2_shares_i;
    end
  end

  assign opnd_valid_o = opnd_valid_q;
  assign opnd_o       = opnd_q;

endmodule

`default_nettype wire

// File: hdl/sme_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module sme_regfile
  import sme_cfg_pkg::*;
(
  input  wire       g_clk_i,                       // Global clock
  input  wire       rst_n_i,                       // Async reset, active low
  input  sme_addr_t rs1_addr_i,                    // Instruction read port 1
  input  sme_addr_t rs2_addr_i,                    // Instruction read port 2
  input  sme_addr_t rd_addr_i,                     // Write address
  input  wire       wen_i,                         // Write enable
  input  sme_data_t wdata_i,                       // Write data
  input  sme_addr_t raddr_i,                       // Bank port read address
  output sme_data_t rs1_rdata_o,
  output sme_data_t rs2_rdata_o,
  output sme_data_t rdata_o
);

  sme_data_t regs_q [NREGS];                       // One share of every register

  always_ff @(posedge g_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NREGS; i++) begin
        regs_q[i] <= '0;                           // All shares start at zero
      end
    end else if (wen_i) begin
      regs_q[rd_addr_i] <= wdata_i;
    end
  end

  // Reads are combinational, no bypass of a same-cycle write
  assign rs1_rdata_o = regs_q[rs1_addr_i];
  assign rs2_rdata_o = regs_q[rs2_addr_i];
  assign rdata_o     = regs_q[raddr_i];

endmodule

`default_nettype wire

// File: hdl/sme_op_pkg.sv
`default_nettype none

package sme_op_pkg;

  import sme_cfg_pkg::*;

  // Share-wise operations
  typedef enum logic [2:0] {
    OP_XOR    = 3'd0,                              // rd = rs1 ^ rs2 per share
    OP_NOT    = 3'd1,                              // rd = rs2, share 0 inverted
    OP_MASK   = 3'd2,                              // Split share 0 into fresh shares
    OP_UNMASK = 3'd3,                              // Fold all shares into share 0
    OP_REMASK = 3'd4                               // New randomness, same value
  } sme_op_e;

  // Instruction as sent by the core
  typedef struct packed {
    sme_op_e   op;
    sme_addr_t rs1_addr;
    sme_addr_t rs2_addr;
    sme_addr_t rd_addr;
  } sme_instr_t;

  // Decoded smectl word
  typedef struct packed {
    sme_cnt_t  d;                                  // Active share count
    sme_bank_t b;                                  // Bank for load/store port
  } sme_ctl_t;

  // Issue to ALU payload
  typedef struct packed {
    sme_op_e     op;
    sme_addr_t   rd_addr;
    sme_cnt_t    d;                                // Already clamped
    sme_shares_t rs1;
    sme_shares_t rs2;
  } sme_opnd_t;

  // ALU to writeback payload
  typedef struct packed {
    sme_addr_t   rd_addr;
    sme_shares_t rd;
  } sme_wb_t;

endpackage

`default_nettype wire

// File: hdl/sme_cfg_pkg.sv
`default_nettype none

package sme_cfg_pkg;

  // Sizes
  // ------------------------------
  localparam int XLEN  = 32;                       // Share data width
  localparam int SMAX  = 4;                        // Number of share banks
  localparam int NREGS = 16;                       // Registers per bank

  // Mask generator start value, must be nonzero
  localparam logic [31:0] PRNG_SEED = 32'h6a09_e667;

  // Vector types
  // ------------------------------
  typedef logic [XLEN-1:0] sme_data_t;             // One share value
  typedef logic [3:0]      sme_addr_t;             // Register index
  typedef logic [1:0]      sme_bank_t;             // Bank / share select
  typedef logic [2:0]      sme_cnt_t;              // Active shares, 1 to SMAX

  // All shares of one register, index is the share number
  typedef sme_data_t [SMAX-1:0] sme_shares_t;

endpackage

`default_nettype wire
